// File: common/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data path word width
`define XLEN 32

// Word address widths of the two memories
`define IMEM_AW 10
`define DMEM_AW 10

// Array depths derived from the address widths
`define IMEM_DEPTH (1 << `IMEM_AW)
`define DMEM_DEPTH (1 << `DMEM_AW)

// Architectural register count
`define NUM_REGS 32

`endif

// File: common/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {WB_ALU = 2'd0, WB_LOAD = 2'd1, WB_PC4 = 2'd2} wb_sel_e;

  // First ALU operand source
  typedef enum logic [1:0] {SRC_A_PC = 2'd0, SRC_A_ZERO = 2'd1, SRC_A_RS1 = 2'd2} src_a_sel_e;

  // Decoded controls for one instruction
  typedef struct packed {
    logic       reg_write;
    logic       mem_write;
    logic       alu_src_imm;
    logic       branch;
    logic       jump;
    src_a_sel_e src_a;
    wb_sel_e    wb;
    alu_op_e    alu_op;
  } ctrl_t;

  // Format views of the instruction word, MSB first
  typedef struct packed {
    logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] rd; opcode_e opcode;
  } r_fmt_t;
  typedef struct packed {
    logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
    logic [4:0] rd; opcode_e opcode;
  } i_fmt_t;
  typedef struct packed {
    logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] imm_4_0; opcode_e opcode;
  } s_fmt_t;
  typedef struct packed {
    logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; opcode_e opcode;
  } b_fmt_t;
  typedef struct packed {
    logic [19:0] imm_31_12; logic [4:0] rd; opcode_e opcode;
  } u_fmt_t;
  typedef struct packed {
    logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
    logic [4:0] rd; opcode_e opcode;
  } j_fmt_t;

  // One word, six decodings
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  // Program load port of the instruction memory
  typedef struct packed {
    logic                we;
    logic [`IMEM_AW-1:0] addr;
    logic [`XLEN-1:0]    data;
  } imem_load_t;

  // Data memory request, word addressed
  typedef struct packed {
    logic                we;
    logic [`DMEM_AW-1:0] addr;
    logic [`XLEN-1:0]    wdata;
  } dmem_req_t;

  // Retirement trace
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic             wen;
    logic [4:0]       rd;
    logic [`XLEN-1:0] wdata;
  } trace_t;

endpackage

// File: core/alu.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module alu import rv_pkg::*; (
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  alu_op_e          op,
  output logic [`XLEN-1:0] result,
  output logic             zero
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Shift amount from low five bits only
  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(`XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // Equality test for BEQ and BNE after SUB
  assign zero = (result == '0);

endmodule

// File: core/control_decoder.sv
`timescale 1ns/10ps

module control_decoder import rv_pkg::*; (
  input  instr_u instr,
  output ctrl_t  ctrl
);

  // Shared funct3 mapping for register and immediate forms
  function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic alt);
    alu_op_e op;
    case (funct3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  logic [2:0] funct3;
  logic       bit30;

  assign funct3 = instr.r.funct3;
  assign bit30  = instr.r.funct7[5];

  always_comb begin
    // Safe default, nothing written, no redirect
    ctrl        = '0;
    ctrl.src_a  = SRC_A_RS1;
    ctrl.wb     = WB_ALU;
    ctrl.alu_op = ALU_ADD;
    case (instr.r.opcode)
      OP_REG: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_decode(funct3, bit30);
      end
      OP_IMM: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        // bit 30 is immediate data except for SRAI
        ctrl.alu_op = alu_decode(funct3, bit30 && funct3 == 3'b101);
      end
      OP_LOAD: begin
        // LW only
        ctrl.reg_write   = (funct3 == 3'b010);
        ctrl.alu_src_imm = 1'b1;
        ctrl.wb          = WB_LOAD;
      end
      OP_STORE: begin
        // SW only
        ctrl.mem_write   = (funct3 == 3'b010);
        ctrl.alu_src_imm = 1'b1;
      end
      OP_BRANCH: begin
        // BEQ and BNE compare through SUB
        ctrl.branch = (funct3 == 3'b000) || (funct3 == 3'b001);
        ctrl.alu_op = ALU_SUB;
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.src_a     = SRC_A_PC;
        ctrl.wb        = WB_PC4;
      end
      OP_LUI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.src_a       = SRC_A_ZERO;
        ctrl.alu_op      = ALU_PASS_B;
      end
      OP_AUIPC: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.src_a       = SRC_A_PC;
      end
      default: ;
    endcase
  end

endmodule

// File: core/imm_gen.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module imm_gen import rv_pkg::*; (
  input  instr_u           instr,
  output logic [`XLEN-1:0] imm
);

  always_comb begin
    case (instr.r.opcode)
      // I format, also covers shift amounts
      OP_IMM, OP_LOAD:
        imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      // S format
      OP_STORE:
        imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      // B format, halfword aligned
      OP_BRANCH:
        imm = {{20{instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
               instr.b.imm_4_1, 1'b0};
      // U format
      OP_LUI, OP_AUIPC:
        imm = {instr.u.imm_31_12, 12'b0};
      // J format
      OP_JAL:
        imm = {{12{instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
               instr.j.imm_10_1, 1'b0};
      default:
        imm = '0;
    endcase
  end

endmodule

// File: core/reg_file.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module reg_file (
  input  logic             CLK,
  input  logic             RESET_N,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  input  logic [4:0]       rd,
  input  logic             we,
  input  logic [`XLEN-1:0] wdata,
  output logic [`XLEN-1:0] rdata1,
  output logic [`XLEN-1:0] rdata2
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // Whole file cleared on reset, x0 never written
  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // Combinational reads, x0 hardwired
  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: core/single_cycle.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module single_cycle import rv_pkg::*; (
  input  logic                CLK,
  input  logic                RESET_N,
  output logic [`IMEM_AW-1:0] iaddr,
  input  logic [`XLEN-1:0]    idata,
  output dmem_req_t           dmem_req,
  input  logic [`XLEN-1:0]    ddata_r,
  output trace_t              trace
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] pc_target;
  logic [`XLEN-1:0] next_pc;
  instr_u           instr;
  ctrl_t            ctrl;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] rdata1;
  logic [`XLEN-1:0] rdata2;
  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_result;
  logic             alu_zero;
  logic [`XLEN-1:0] wb_data;
  logic             reg_we;
  logic             take_branch;

  assign instr = idata;

  control_decoder i_ctrl (
    .instr (instr),
    .ctrl  (ctrl)
  );

  imm_gen i_imm (
    .instr (instr),
    .imm   (imm)
  );

  // Strobes held off while in reset
  assign reg_we = ctrl.reg_write & RESET_N;

  reg_file i_regs (
    .CLK     (CLK),
    .RESET_N (RESET_N),
    .rs1     (instr.r.rs1),
    .rs2     (instr.r.rs2),
    .rd      (instr.r.rd),
    .we      (reg_we),
    .wdata   (wb_data),
    .rdata1  (rdata1),
    .rdata2  (rdata2)
  );

  // Operand A: PC for AUIPC and JAL, zero for LUI
  always_comb begin
    case (ctrl.src_a)
      SRC_A_PC:   alu_a = pc;
      SRC_A_ZERO: alu_a = '0;
      default:    alu_a = rdata1;
    endcase
  end

  assign alu_b = ctrl.alu_src_imm ? imm : rdata2;

  alu i_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  assign pc_plus4  = pc + `XLEN'd4;
  assign pc_target = pc + imm;

  // funct3 bit 0 tells BNE from BEQ
  assign take_branch = ctrl.jump |
                       (ctrl.branch & (instr.b.funct3[0] ? ~alu_zero : alu_zero));
  assign next_pc = take_branch ? pc_target : pc_plus4;

  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  // Write-back select
  always_comb begin
    case (ctrl.wb)
      WB_LOAD: wb_data = ddata_r;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  // Word addresses, byte offset dropped
  assign iaddr          = pc[`IMEM_AW+1:2];
  assign dmem_req.we    = ctrl.mem_write & RESET_N;
  assign dmem_req.addr  = alu_result[`DMEM_AW+1:2];
  assign dmem_req.wdata = rdata2;

  // Retirement view for the checker
  assign trace.pc    = pc;
  assign trace.wen   = reg_we;
  assign trace.rd    = instr.r.rd;
  assign trace.wdata = wb_data;

endmodule

// File: logic/dmem.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module dmem import rv_pkg::*; (
  input  logic             CLK,
  input  dmem_req_t        req,
  output logic [`XLEN-1:0] rdata
);

  logic [`XLEN-1:0] mem [`DMEM_DEPTH];

  // Store lands at the end of the cycle
  always_ff @(posedge CLK) begin
    if (req.we) begin
      mem[req.addr] <= req.wdata;
    end
  end

  // Load data same cycle
  assign rdata = mem[req.addr];

endmodule

// File: logic/imem.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module imem import rv_pkg::*; (
  input  logic                CLK,
  input  imem_load_t          load,
  input  logic [`IMEM_AW-1:0] addr,
  output logic [`XLEN-1:0]    data
);

  logic [`XLEN-1:0] mem [`IMEM_DEPTH];

  // Program load port
  always_ff @(posedge CLK) begin
    if (load.we) begin
      mem[load.addr] <= load.data;
    end
  end

  // Fetch, no latency
  assign data = mem[addr];

endmodule

// File: logic/rv_system.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module rv_system import rv_pkg::*; (
  input  logic       CLK,
  input  logic       RESET_N,
  input  imem_load_t prog,
  output trace_t     trace,
  output dmem_req_t  store
);

  logic [`IMEM_AW-1:0] iaddr;
  logic [`XLEN-1:0]    idata;
  logic [`XLEN-1:0]    ddata_r;

  single_cycle i_core (
    .CLK      (CLK),
    .RESET_N  (RESET_N),
    .iaddr    (iaddr),
    .idata    (idata),
    .dmem_req (store),
    .ddata_r  (ddata_r),
    .trace    (trace)
  );

  imem i_imem (
    .CLK  (CLK),
    .load (prog),
    .addr (iaddr),
    .data (idata)
  );

  // Store request also seen at the top
  dmem i_dmem (
    .CLK   (CLK),
    .req   (store),
    .rdata (ddata_r)
  );

endmodule

// File: tb/tb_rv_system.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module tb_rv_system import rv_pkg::*;;

  localparam int MAX_CYCLES = 2000;

  logic       CLK;
  logic       RESET_N;
  imem_load_t prog;
  trace_t     trace;
  dmem_req_t  store;

  // Program image and reference state
  logic [31:0] prog_words [$];
  logic [31:0] model_regs [32];
  logic [31:0] model_mem [int];
  logic [31:0] model_pc;
  int          cycles;

  rv_system i_rv_system (
    .CLK     (CLK),
    .RESET_N (RESET_N),
    .prog    (prog),
    .trace   (trace),
    .store   (store)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Run limit
  initial cycles = 0;
  always @(posedge CLK) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1);
    end
  end

  // Instruction encoders, one per format
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // LUI plus ADDI, upper part rounded for the signed low half
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] upper;
    upper = (v + 32'h800) >> 12;
    prog_words.push_back(u_type(upper[19:0], rd, 7'b0110111));
    prog_words.push_back(i_type(v[11:0], rd, 3'b000, rd, 7'b0010011));
  endtask

  // Spec arithmetic for funct3, alt selects SUB or SRA
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    logic [31:0]        r;
    sa = a;
    case (f3)
      3'b000:  r = alt ? a - b : a + b;
      3'b001:  r = a << b[4:0];
      3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  r = (a < b) ? 32'd1 : 32'd0;
      3'b100:  r = a ^ b;
      3'b110:  r = a | b;
      3'b111:  r = a & b;
      default: begin
        if (alt) r = sa >>> b[4:0];
        else r = a >> b[4:0];
      end
    endcase
    return r;
  endfunction

  // One retirement of the reference model
  task automatic model_step(output trace_t t, output dmem_req_t s);
    logic [31:0] w, a, b, next, addr;
    logic [4:0]  rd;
    logic [2:0]  f3;
    w    = prog_words[model_pc >> 2];
    rd   = w[11:7];
    f3   = w[14:12];
    a    = model_regs[w[19:15]];
    b    = model_regs[w[24:20]];
    next = model_pc + 32'd4;
    t    = '0;
    s    = '0;
    t.pc = model_pc;
    t.rd = rd;
    case (w[6:0])
      7'b0110011: begin
        t.wen   = 1'b1;
        t.wdata = alu_ref(f3, w[30], a, b);
      end
      7'b0010011: begin
        t.wen   = 1'b1;
        t.wdata = alu_ref(f3, w[30] && f3 == 3'b101, a, {{20{w[31]}}, w[31:20]});
      end
      7'b0110111: begin
        t.wen   = 1'b1;
        t.wdata = {w[31:12], 12'b0};
      end
      7'b0010111: begin
        t.wen   = 1'b1;
        t.wdata = model_pc + {w[31:12], 12'b0};
      end
      7'b1101111: begin
        t.wen   = 1'b1;
        t.wdata = model_pc + 32'd4;
        next    = model_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'b1100011: begin
        // BEQ on equal, BNE on different
        if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
          next = model_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      7'b0000011: begin
        addr    = a + {{20{w[31]}}, w[31:20]};
        t.wen   = 1'b1;
        t.wdata = model_mem[int'(addr[`DMEM_AW+1:2])];
      end
      7'b0100011: begin
        addr    = a + {{20{w[31]}}, w[31:25], w[11:7]};
        s.we    = 1'b1;
        s.addr  = addr[`DMEM_AW+1:2];
        s.wdata = b;
        model_mem[int'(s.addr)] = b;
      end
      default: ;
    endcase
    if (t.wen && rd != 5'd0) model_regs[rd] = t.wdata;
    model_pc = next;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
    $display("Test failed");
    $fatal(1);
  endtask

  // rd and wdata only matter with a write
  task automatic check_trace(input trace_t exp, input trace_t act);
    if (act.pc !== exp.pc) report_mismatch("trace.pc", exp.pc, act.pc);
    if (act.wen !== exp.wen) report_mismatch("trace.wen", 32'(exp.wen), 32'(act.wen));
    if (exp.wen && act.rd !== exp.rd) report_mismatch("trace.rd", 32'(exp.rd), 32'(act.rd));
    if (exp.wen && act.wdata !== exp.wdata)
      report_mismatch("trace.wdata", exp.wdata, act.wdata);
  endtask

  task automatic check_store(input dmem_req_t exp, input dmem_req_t act);
    if (act.we !== exp.we) report_mismatch("store.we", 32'(exp.we), 32'(act.we));
    if (exp.we && act.addr !== exp.addr)
      report_mismatch("store.addr", 32'(exp.addr), 32'(act.addr));
    if (exp.we && act.wdata !== exp.wdata)
      report_mismatch("store.wdata", exp.wdata, act.wdata);
  endtask

  // Reset, load, release, then check each retirement
  task automatic run_program(input int steps);
    trace_t    exp_t;
    dmem_req_t exp_s;
    @(posedge CLK);
    #1;
    RESET_N = 1'b0;
    for (int n = 0; n < prog_words.size(); n++) begin
      prog.we   = 1'b1;
      prog.addr = n[`IMEM_AW-1:0];
      prog.data = prog_words[n];
      @(posedge CLK);
      #1;
    end
    prog = '0;
    // In reset the PC sits at zero and both strobes stay low
    exp_t = '0;
    exp_s = '0;
    repeat (16) begin
      @(posedge CLK);
      #1;
      check_trace(exp_t, trace);
      check_store(exp_s, store);
    end
    model_pc = '0;
    foreach (model_regs[i]) model_regs[i] = '0;
    RESET_N = 1'b1;
    for (int n = 0; n < steps; n++) begin
      #1;
      model_step(exp_t, exp_s);
      check_trace(exp_t, trace);
      check_store(exp_s, store);
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic test_reg_ops();
    logic [2:0] f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [6:0] f7s [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20,
                             7'h00, 7'h00};
    prog_words.delete();
    // Positive odd x1 and negative x2, shift amount never zero
    load_const(5'd1, ($urandom() & 32'h7fff_ffff) | 32'h1);
    load_const(5'd2, $urandom() | 32'h8000_0000);
    // Both operand orders, so SLT and SLTU disagree
    for (int k = 0; k < 10; k++) begin
      prog_words.push_back(r_type(f7s[k], 5'd2, 5'd1, f3s[k], 5'(10 + k)));
      prog_words.push_back(r_type(f7s[k], 5'd1, 5'd2, f3s[k], 5'(20 + k)));
    end
    prog_words.push_back(j_type('0, 5'd0));
    run_program(prog_words.size() + 2);
  endtask

  task automatic test_imm_ops();
    prog_words.delete();
    load_const(5'd1, $urandom() | 32'h8000_0000);
    prog_words.push_back(i_type(12'(-5), 5'd1, 3'b000, 5'd2, 7'b0010011));
    prog_words.push_back(i_type(12'(-1), 5'd1, 3'b010, 5'd3, 7'b0010011));
    prog_words.push_back(i_type(12'(-1), 5'd1, 3'b011, 5'd4, 7'b0010011));
    prog_words.push_back(i_type(12'hfa5, 5'd1, 3'b100, 5'd5, 7'b0010011));
    prog_words.push_back(i_type(12'h0f0, 5'd1, 3'b110, 5'd6, 7'b0010011));
    prog_words.push_back(i_type(12'(-16), 5'd1, 3'b111, 5'd7, 7'b0010011));
    prog_words.push_back(i_type(12'd7, 5'd1, 3'b001, 5'd8, 7'b0010011));
    prog_words.push_back(i_type(12'd13, 5'd1, 3'b101, 5'd9, 7'b0010011));
    prog_words.push_back(i_type(12'h40d, 5'd1, 3'b101, 5'd10, 7'b0010011));
    prog_words.push_back(u_type(20'habcde, 5'd11, 7'b0110111));
    prog_words.push_back(u_type(20'h12345, 5'd12, 7'b0010111));
    prog_words.push_back(u_type(20'hfffff, 5'd13, 7'b0010111));
    prog_words.push_back(j_type('0, 5'd0));
    run_program(prog_words.size() + 2);
  endtask

  task automatic test_mem();
    prog_words.delete();
    prog_words.push_back(i_type(12'h040, 5'd0, 3'b000, 5'd1, 7'b0010011));
    load_const(5'd2, $urandom());
    load_const(5'd3, $urandom());
    prog_words.push_back(s_type(12'd0, 5'd2, 5'd1));
    prog_words.push_back(s_type(12'd8, 5'd3, 5'd1));
    prog_words.push_back(s_type(12'(-4), 5'd3, 5'd1));
    prog_words.push_back(s_type(12'h7fc, 5'd2, 5'd0));
    prog_words.push_back(i_type(12'd0, 5'd1, 3'b010, 5'd4, 7'b0000011));
    prog_words.push_back(i_type(12'd8, 5'd1, 3'b010, 5'd5, 7'b0000011));
    prog_words.push_back(i_type(12'(-4), 5'd1, 3'b010, 5'd6, 7'b0000011));
    prog_words.push_back(i_type(12'h7fc, 5'd0, 3'b010, 5'd7, 7'b0000011));
    prog_words.push_back(j_type('0, 5'd0));
    run_program(prog_words.size() + 2);
  endtask

  // Path 0, 4, 8, 12, 24, 28, 32, 20, 40, 48
  task automatic test_branch();
    prog_words.delete();
    prog_words.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
    prog_words.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd2, 7'b0010011));
    prog_words.push_back(i_type(12'd7, 5'd0, 3'b000, 5'd3, 7'b0010011));
    prog_words.push_back(b_type(13'd12, 5'd2, 5'd1, 3'b000));
    prog_words.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd4, 7'b0010011));
    prog_words.push_back(j_type(21'd20, 5'd0));
    prog_words.push_back(b_type(13'd8, 5'd2, 5'd1, 3'b001));
    prog_words.push_back(b_type(13'd8, 5'd3, 5'd1, 3'b000));
    prog_words.push_back(b_type(13'(-12), 5'd3, 5'd1, 3'b001));
    prog_words.push_back(i_type(12'd2, 5'd0, 3'b000, 5'd4, 7'b0010011));
    prog_words.push_back(j_type(21'd8, 5'd5));
    prog_words.push_back(i_type(12'd3, 5'd0, 3'b000, 5'd6, 7'b0010011));
    prog_words.push_back(j_type('0, 5'd0));
    run_program(12);
  endtask

  task automatic test_x0();
    prog_words.delete();
    prog_words.push_back(i_type(12'h123, 5'd0, 3'b000, 5'd0, 7'b0010011));
    prog_words.push_back(i_type(12'd9, 5'd0, 3'b000, 5'd1, 7'b0010011));
    prog_words.push_back(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd2));
    prog_words.push_back(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd3));
    prog_words.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd4, 7'b0010011));
    prog_words.push_back(j_type('0, 5'd0));
    run_program(prog_words.size() + 2);
  endtask

  // Fill registers, then read them back after a fresh reset
  task automatic test_reset_clear();
    prog_words.delete();
    load_const(5'd1, $urandom());
    load_const(5'd2, $urandom());
    load_const(5'd3, $urandom());
    prog_words.push_back(j_type('0, 5'd0));
    run_program(prog_words.size() + 1);
    prog_words.delete();
    prog_words.push_back(r_type(7'h00, 5'd0, 5'd1, 3'b000, 5'd4));
    prog_words.push_back(r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd5));
    prog_words.push_back(i_type(12'd0, 5'd3, 3'b000, 5'd6, 7'b0010011));
    prog_words.push_back(j_type('0, 5'd0));
    run_program(prog_words.size() + 2);
  endtask

  initial begin
    RESET_N = 1'b0;
    prog    = '0;
    void'($urandom(17));
    test_reg_ops();
    test_imm_ops();
    test_mem();
    test_branch();
    test_x0();
    test_reset_clear();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+common
common/rv_pkg.sv
core/control_decoder.sv
core/imm_gen.sv
core/alu.sv
core/reg_file.sv
core/single_cycle.sv
logic/imem.sv
logic/dmem.sv
logic/rv_system.sv
tb/tb_rv_system.sv
